/* include/host_chan_settings.svh */
`ifndef HOST_CHAN_SETTINGS_SVH
`define HOST_CHAN_SETTINGS_SVH

// Bytes in one memory line
`define HC_LINE_BYTES 8
// Line width in bits
`define HC_DATA_W (`HC_LINE_BYTES * 8)
// Index of a byte within a line
`define HC_BYTE_IDX_W 3
// A byte count one bit wider than the index so that it can reach a full line
`define HC_BYTE_LEN_W (`HC_BYTE_IDX_W + 1)
// The line address is 8 bits wide so the memory holds 256 lines
`define HC_ADDR_W 8
`define HC_MDATA_W 8
// Burst length minus one, so a burst spans one to four lines
`define HC_CL_LEN_W 2
// Almost-full asserts at this fill level
`define HC_TX_ALM_FULL 4
// Four spare entries catch the requests that are still in flight after almost-full
`define HC_REQ_FIFO_DEPTH (`HC_TX_ALM_FULL + 4)
`define HC_TRACKER_DEPTH 8
// Cycles from an accepted read command to its first line
`define HC_MEM_RD_LATENCY 2

`endif

/* logic/host_chan_pkg.sv */
`include "host_chan_settings.svh"

package host_chan_pkg;

    typedef logic [`HC_ADDR_W-1:0] addr_t;
    typedef logic [`HC_CL_LEN_W-1:0] cl_len_t;
    typedef logic [`HC_MDATA_W-1:0] mdata_t;

    // A read request as it waits in the c0 request FIFO
    typedef struct packed {
        addr_t address;
        cl_len_t cl_len;
        mdata_t mdata;
    } rd_req_t;

    // One write beat or fence as it waits in the c1 request FIFO
    typedef struct packed {
        addr_t address;
        cl_len_t cl_len;
        mdata_t mdata;
        logic sop;
        logic fence;
        // Partial write mode uses the byte range below
        logic mode;
        logic [`HC_BYTE_IDX_W-1:0] byte_start;
        logic [`HC_BYTE_LEN_W-1:0] byte_len;
        // The end of the byte range is summed before the FIFO to keep the adder off the mask path
        logic [`HC_BYTE_LEN_W-1:0] byte_end;
        logic [`HC_DATA_W-1:0] data;
    } wr_req_t;

    // What a read response needs once the command has left
    typedef struct packed {
        cl_len_t cl_len;
        mdata_t mdata;
    } rd_track_t;

    // Holds one entry per write burst or fence rather than per beat
    typedef struct packed {
        logic is_fence;
        cl_len_t cl_len;
        mdata_t mdata;
    } wr_track_t;

endpackage

/* logic/host_chan_top.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

module host_chan_top
(
    input  logic clk,
    input  logic reset_n,
    // c0 carries reads
    input  logic c0_valid,
    input  logic [`HC_ADDR_W-1:0] c0_address,
    input  logic [`HC_CL_LEN_W-1:0] c0_cl_len,
    input  logic [`HC_MDATA_W-1:0] c0_mdata,
    output logic c0_almost_full,
    output logic c0_rsp_valid,
    output logic [`HC_DATA_W-1:0] c0_rsp_data,
    output logic [`HC_CL_LEN_W-1:0] c0_rsp_cl_num,
    output logic [`HC_MDATA_W-1:0] c0_rsp_mdata,
    // c1 carries writes and fences
    input  logic c1_valid,
    input  logic c1_sop,
    input  logic c1_fence,
    input  logic [`HC_ADDR_W-1:0] c1_address,
    input  logic [`HC_CL_LEN_W-1:0] c1_cl_len,
    input  logic [`HC_MDATA_W-1:0] c1_mdata,
    input  logic c1_mode,
    input  logic [`HC_BYTE_IDX_W-1:0] c1_byte_start,
    input  logic [`HC_BYTE_LEN_W-1:0] c1_byte_len,
    input  logic [`HC_DATA_W-1:0] c1_data,
    output logic c1_almost_full,
    output logic c1_rsp_valid,
    output logic [`HC_CL_LEN_W-1:0] c1_rsp_cl_num,
    output logic [`HC_MDATA_W-1:0] c1_rsp_mdata,
    output logic c1_rsp_fence
);
    // Both channels share the one memory port through the arbiter
    mem_bus_if rd_bus();
    mem_bus_if wr_bus();
    mem_bus_if mem_bus();

    read_channel rd_chan (
        .clk,
        .reset_n,
        .c0_valid,
        .c0_address,
        .c0_cl_len,
        .c0_mdata,
        .c0_almost_full,
        .c0_rsp_valid,
        .c0_rsp_data,
        .c0_rsp_cl_num,
        .c0_rsp_mdata,
        .bus(rd_bus.requester)
    );

    write_channel wr_chan (
        .clk,
        .reset_n,
        .c1_valid,
        .c1_sop,
        .c1_fence,
        .c1_address,
        .c1_cl_len,
        .c1_mdata,
        .c1_mode,
        .c1_byte_start,
        .c1_byte_len,
        .c1_data,
        .c1_almost_full,
        .c1_rsp_valid,
        .c1_rsp_cl_num,
        .c1_rsp_mdata,
        .c1_rsp_fence,
        .bus(wr_bus.requester)
    );

    mem_arbiter arb (
        .clk,
        .reset_n,
        .rd(rd_bus.responder),
        .wr(wr_bus.responder),
        .mem(mem_bus.requester)
    );

    // Stands in for host memory
    line_memory mem (
        .clk,
        .reset_n,
        .bus(mem_bus.responder)
    );

endmodule

/* logic/line_memory.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

module line_memory
(
    input logic clk,
    input logic reset_n,
    mem_bus_if.responder bus
);
    localparam int WAIT_W = $clog2(`HC_MEM_RD_LATENCY);

    // Starts zero filled at power up
    logic [`HC_DATA_W-1:0] lines [2**`HC_ADDR_W] = '{default: '0};
    logic accept;
    logic rd_active;
    logic [WAIT_W-1:0] rd_wait;
    logic [`HC_CL_LEN_W-1:0] rd_left;
    logic [`HC_ADDR_W-1:0] rd_addr;

    // The port stays busy while a read burst is pending or streaming
    assign bus.waitrequest = rd_active;
    assign accept = bus.cmd_valid && !bus.waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_active <= 1'b0;
            bus.rdata_valid <= 1'b0;
            bus.wr_rsp_valid <= 1'b0;
        end
        else
        begin
            bus.rdata_valid <= rd_active && (rd_wait == '0);
            // One ack per write burst or fence
            bus.wr_rsp_valid <= accept && bus.cmd_last && (bus.cmd_write || bus.cmd_fence);
            if (accept && !bus.cmd_write && !bus.cmd_fence)
            begin
                rd_active <= 1'b1;
                // The output register supplies one cycle of the latency
                rd_wait <= WAIT_W'(`HC_MEM_RD_LATENCY - 2);
                rd_addr <= bus.address;
                rd_left <= bus.burst_len;
            end
            else if (rd_active)
            begin
                if (rd_wait != '0)
                    rd_wait <= rd_wait - 1'b1;
                else
                begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_left == '0)
                        rd_active <= 1'b0;
                    else
                        rd_left <= rd_left - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && bus.cmd_write)
        begin
            for (int b = 0; b < `HC_LINE_BYTES; b++)
            begin
                if (bus.byteenable[b])
                    lines[bus.address][8*b +: 8] <= bus.writedata[8*b +: 8];
            end
        end
        if (rd_active && (rd_wait == '0))
            bus.rdata <= lines[rd_addr];
    end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
(
    input logic clk,
    input logic reset_n,
    mem_bus_if.responder rd,
    mem_bus_if.responder wr,
    mem_bus_if.requester mem
);
    logic grant_wr;
    // Remembers which side won last so the other side goes next
    logic last_wr;
    // Holds the port for the write side until the burst's last beat goes out
    logic locked;
    logic accept;

    always_comb
    begin
        if (locked)
            grant_wr = 1'b1;
        else if (rd.cmd_valid && wr.cmd_valid)
            grant_wr = !last_wr;
        else
            grant_wr = wr.cmd_valid;
    end

    assign mem.cmd_valid = grant_wr ? wr.cmd_valid : rd.cmd_valid;
    assign mem.cmd_write = grant_wr ? wr.cmd_write : rd.cmd_write;
    assign mem.cmd_fence = grant_wr ? wr.cmd_fence : rd.cmd_fence;
    assign mem.cmd_last = grant_wr ? wr.cmd_last : rd.cmd_last;
    assign mem.address = grant_wr ? wr.address : rd.address;
    assign mem.burst_len = grant_wr ? wr.burst_len : rd.burst_len;
    assign mem.writedata = grant_wr ? wr.writedata : rd.writedata;
    assign mem.byteenable = grant_wr ? wr.byteenable : rd.byteenable;

    // The side without the grant sees the port as busy
    assign rd.waitrequest = grant_wr || mem.waitrequest;
    assign wr.waitrequest = !grant_wr || mem.waitrequest;

    // Read data and write acks each belong to one side only
    assign rd.rdata_valid = mem.rdata_valid;
    assign rd.rdata = mem.rdata;
    assign rd.wr_rsp_valid = 1'b0;
    assign wr.rdata_valid = 1'b0;
    assign wr.rdata = '0;
    assign wr.wr_rsp_valid = mem.wr_rsp_valid;

    assign accept = mem.cmd_valid && !mem.waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            last_wr <= 1'b0;
            locked <= 1'b0;
        end
        else if (accept)
        begin
            last_wr <= grant_wr;
            if (grant_wr)
                locked <= !wr.cmd_last;
        end
    end

endmodule

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

// Line-oriented memory bus with one command side and one response side
interface mem_bus_if;
    // A command is accepted in any cycle with cmd_valid high and waitrequest low
    logic cmd_valid;
    logic cmd_write;
    logic cmd_fence;
    // Set on the final beat of a write burst and on every fence
    logic cmd_last;
    logic [`HC_ADDR_W-1:0] address;
    logic [`HC_CL_LEN_W-1:0] burst_len;
    logic [`HC_DATA_W-1:0] writedata;
    logic [`HC_LINE_BYTES-1:0] byteenable;

    // Responses come back in command order
    logic waitrequest;
    logic rdata_valid;
    logic [`HC_DATA_W-1:0] rdata;
    logic wr_rsp_valid;

    modport requester
    (
        output cmd_valid, cmd_write, cmd_fence, cmd_last,
        output address, burst_len, writedata, byteenable,
        input  waitrequest, rdata_valid, rdata, wr_rsp_valid
    );

    modport responder
    (
        input  cmd_valid, cmd_write, cmd_fence, cmd_last,
        input  address, burst_len, writedata, byteenable,
        output waitrequest, rdata_valid, rdata, wr_rsp_valid
    );

endinterface

/* logic/read_channel.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

module read_channel
(
    input  logic clk,
    input  logic reset_n,
    input  logic c0_valid,
    input  logic [`HC_ADDR_W-1:0] c0_address,
    input  logic [`HC_CL_LEN_W-1:0] c0_cl_len,
    input  logic [`HC_MDATA_W-1:0] c0_mdata,
    output logic c0_almost_full,
    output logic c0_rsp_valid,
    output logic [`HC_DATA_W-1:0] c0_rsp_data,
    output logic [`HC_CL_LEN_W-1:0] c0_rsp_cl_num,
    output logic [`HC_MDATA_W-1:0] c0_rsp_mdata,
    mem_bus_if.requester bus
);
    host_chan_pkg::rd_req_t enq_req;
    host_chan_pkg::rd_req_t req;
    host_chan_pkg::rd_track_t trk_in;
    host_chan_pkg::rd_track_t trk;
    logic req_not_empty;
    logic trk_not_full;
    logic accept;
    logic trk_deq;
    logic [`HC_CL_LEN_W-1:0] cl_num;

    assign enq_req = '{address: c0_address, cl_len: c0_cl_len, mdata: c0_mdata};

    // Requests wait here so that the accelerator can keep sending after almost-full
    req_fifo #(
        .payload_t(host_chan_pkg::rd_req_t),
        .DEPTH(`HC_REQ_FIFO_DEPTH),
        .THRESHOLD(`HC_TX_ALM_FULL)
    ) req_q (
        .clk,
        .reset_n,
        .enq_data(enq_req),
        .enq_en(c0_valid),
        .almost_full(c0_almost_full),
        .not_full(),
        .first(req),
        .deq_en(accept),
        .not_empty(req_not_empty)
    );

    // A read goes out as one burst command
    assign bus.cmd_valid = req_not_empty && trk_not_full;
    assign bus.cmd_write = 1'b0;
    assign bus.cmd_fence = 1'b0;
    assign bus.cmd_last = 1'b1;
    assign bus.address = req.address;
    assign bus.burst_len = req.cl_len;
    assign bus.writedata = '0;
    assign bus.byteenable = '1;
    assign accept = bus.cmd_valid && !bus.waitrequest;

    // Each burst in flight keeps its length and tag until its last line returns
    assign trk_in = '{cl_len: req.cl_len, mdata: req.mdata};
    assign trk_deq = bus.rdata_valid && (cl_num == trk.cl_len);

    req_fifo #(
        .payload_t(host_chan_pkg::rd_track_t),
        .DEPTH(`HC_TRACKER_DEPTH),
        .THRESHOLD(`HC_TRACKER_DEPTH)
    ) trk_q (
        .clk,
        .reset_n,
        .enq_data(trk_in),
        .enq_en(accept),
        .almost_full(),
        .not_full(trk_not_full),
        .first(trk),
        .deq_en(trk_deq),
        .not_empty()
    );

    // Line counter within the current burst
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cl_num <= '0;
            c0_rsp_valid <= 1'b0;
        end
        else
        begin
            if (trk_deq)
                cl_num <= '0;
            else if (bus.rdata_valid)
                cl_num <= cl_num + 1'b1;
            c0_rsp_valid <= bus.rdata_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        c0_rsp_data <= bus.rdata;
        c0_rsp_cl_num <= cl_num;
        c0_rsp_mdata <= trk.mdata;
    end

endmodule

/* logic/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo
#(
    parameter type payload_t = logic,
    parameter int DEPTH = 8,
    parameter int THRESHOLD = 4
)
(
    input  logic clk,
    input  logic reset_n,
    input  payload_t enq_data,
    input  logic enq_en,
    output logic almost_full,
    output logic not_full,
    output payload_t first,
    input  logic deq_en,
    output logic not_empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Circular buffer behind the registered head
    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] buf_count;
    logic [CNT_W-1:0] total;
    logic head_valid;
    logic head_free;
    logic load_buf;
    logic load_enq;
    logic push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // The head refills when it is empty or being popped this cycle
    assign head_free = !head_valid || deq_en;
    // The oldest buffered entry has priority over a new one
    assign load_buf = head_free && (buf_count != '0);
    // An entry bypasses the buffer only when the buffer is empty
    assign load_enq = head_free && (buf_count == '0) && enq_en;
    assign push = enq_en && !load_enq;

    // The head register counts toward the fill level
    assign total = buf_count + CNT_W'(head_valid);
    assign not_empty = head_valid;
    assign not_full = (total < CNT_W'(DEPTH));
    assign almost_full = (total >= CNT_W'(THRESHOLD));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            buf_count <= '0;
            head_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (load_buf)
                rd_ptr <= next_ptr(rd_ptr);
            if (head_free)
                head_valid <= load_buf || load_enq;
            buf_count <= buf_count + CNT_W'(push) - CNT_W'(load_buf);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= enq_data;
        if (load_buf)
            first <= mem[rd_ptr];
        else if (load_enq)
            first <= enq_data;
    end

endmodule

/* logic/write_channel.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

module write_channel
(
    input  logic clk,
    input  logic reset_n,
    input  logic c1_valid,
    input  logic c1_sop,
    input  logic c1_fence,
    input  logic [`HC_ADDR_W-1:0] c1_address,
    input  logic [`HC_CL_LEN_W-1:0] c1_cl_len,
    input  logic [`HC_MDATA_W-1:0] c1_mdata,
    input  logic c1_mode,
    input  logic [`HC_BYTE_IDX_W-1:0] c1_byte_start,
    input  logic [`HC_BYTE_LEN_W-1:0] c1_byte_len,
    input  logic [`HC_DATA_W-1:0] c1_data,
    output logic c1_almost_full,
    output logic c1_rsp_valid,
    output logic [`HC_CL_LEN_W-1:0] c1_rsp_cl_num,
    output logic [`HC_MDATA_W-1:0] c1_rsp_mdata,
    output logic c1_rsp_fence,
    mem_bus_if.requester bus
);
    host_chan_pkg::wr_req_t enq_req;
    host_chan_pkg::wr_req_t req;
    host_chan_pkg::wr_track_t trk_in;
    host_chan_pkg::wr_track_t trk;
    logic req_not_empty;
    logic trk_not_full;
    logic accept;
    logic [`HC_CL_LEN_W-1:0] beat;
    logic [`HC_CL_LEN_W-1:0] beat_idx;
    logic [`HC_CL_LEN_W-1:0] cur_len;
    logic [`HC_CL_LEN_W-1:0] len_r;
    logic [`HC_ADDR_W-1:0] base_addr;
    logic [`HC_LINE_BYTES-1:0] byte_mask;

    assign enq_req = '{
        address: c1_address,
        cl_len: c1_cl_len,
        mdata: c1_mdata,
        sop: c1_sop,
        fence: c1_fence,
        mode: c1_mode,
        byte_start: c1_byte_start,
        byte_len: c1_byte_len,
        byte_end: c1_byte_start + c1_byte_len,
        data: c1_data
    };

    req_fifo #(
        .payload_t(host_chan_pkg::wr_req_t),
        .DEPTH(`HC_REQ_FIFO_DEPTH),
        .THRESHOLD(`HC_TX_ALM_FULL)
    ) req_q (
        .clk,
        .reset_n,
        .enq_data(enq_req),
        .enq_en(c1_valid),
        .almost_full(c1_almost_full),
        .not_full(),
        .first(req),
        .deq_en(accept),
        .not_empty(req_not_empty)
    );

    // The sop beat opens a burst with its own address and length
    assign beat_idx = req.sop ? '0 : beat;
    assign cur_len = req.sop ? req.cl_len : len_r;

    // Bytes from byte_start up to but not including byte_end
    always_comb
    begin
        for (int i = 0; i < `HC_LINE_BYTES; i++)
            byte_mask[i] = (i >= int'(req.byte_start)) && (i < int'(req.byte_end));
    end

    // Every beat becomes one command, and a fence goes out at address zero
    assign bus.cmd_valid = req_not_empty && trk_not_full;
    assign bus.cmd_write = !req.fence;
    assign bus.cmd_fence = req.fence;
    assign bus.cmd_last = req.fence || (beat_idx == cur_len);
    assign bus.address = req.fence ? '0 : (req.sop ? req.address : base_addr + beat);
    assign bus.burst_len = req.fence ? '0 : cur_len;
    assign bus.writedata = req.data;
    assign bus.byteenable = req.mode ? byte_mask : '1;
    assign accept = bus.cmd_valid && !bus.waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            beat <= '0;
        else if (accept)
            beat <= bus.cmd_last ? '0 : beat_idx + 1'b1;
    end

    // Later beats take their line address from the first one
    always_ff @(posedge clk)
    begin
        if (accept && req.sop)
        begin
            base_addr <= req.address;
            len_r <= req.cl_len;
        end
    end

    // The memory answers once per burst, so the tracker holds bursts and fences
    assign trk_in = '{is_fence: req.fence, cl_len: req.fence ? '0 : req.cl_len, mdata: req.mdata};

    req_fifo #(
        .payload_t(host_chan_pkg::wr_track_t),
        .DEPTH(`HC_TRACKER_DEPTH),
        .THRESHOLD(`HC_TRACKER_DEPTH)
    ) trk_q (
        .clk,
        .reset_n,
        .enq_data(trk_in),
        .enq_en(accept && (req.sop || req.fence)),
        .almost_full(),
        .not_full(trk_not_full),
        .first(trk),
        .deq_en(bus.wr_rsp_valid),
        .not_empty()
    );

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            c1_rsp_valid <= 1'b0;
        else
            c1_rsp_valid <= bus.wr_rsp_valid;
    end

    // The response reports the last line number of the burst
    always_ff @(posedge clk)
    begin
        c1_rsp_cl_num <= trk.cl_len;
        c1_rsp_mdata <= trk.mdata;
        c1_rsp_fence <= trk.is_fence;
    end

endmodule

/* sim.f */
+incdir+include
logic/host_chan_pkg.sv
logic/mem_bus_if.sv
logic/req_fifo.sv
logic/read_channel.sv
logic/write_channel.sv
logic/mem_arbiter.sv
logic/line_memory.sv
logic/host_chan_top.sv
verif/tb_clock_gen.sv
verif/tb_host_chan.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free running clock with a short synchronous reset at the start
module tb_clock_gen
(
    output logic clk,
    output logic reset_n
);
    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        // Reset spans two rising edges
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    end

    // Half period of 5 ns gives a 10 ns clock
    always #5 clk = ~clk;

endmodule

/* verif/tb_host_chan.sv */
`timescale 1ns/1ps
`include "host_chan_settings.svh"

module tb_host_chan;
    // Longest stall the accelerator side accepts before giving up
    localparam int STALL_LIMIT = 200;
    // Longest wait for all outstanding responses
    localparam int RSP_LIMIT = 2000;

    logic clk;
    logic reset_n;
    logic c0_valid;
    logic [`HC_ADDR_W-1:0] c0_address;
    logic [`HC_CL_LEN_W-1:0] c0_cl_len;
    logic [`HC_MDATA_W-1:0] c0_mdata;
    logic c0_almost_full;
    logic c0_rsp_valid;
    logic [`HC_DATA_W-1:0] c0_rsp_data;
    logic [`HC_CL_LEN_W-1:0] c0_rsp_cl_num;
    logic [`HC_MDATA_W-1:0] c0_rsp_mdata;
    logic c1_valid;
    logic c1_sop;
    logic c1_fence;
    logic [`HC_ADDR_W-1:0] c1_address;
    logic [`HC_CL_LEN_W-1:0] c1_cl_len;
    logic [`HC_MDATA_W-1:0] c1_mdata;
    logic c1_mode;
    logic [`HC_BYTE_IDX_W-1:0] c1_byte_start;
    logic [`HC_BYTE_LEN_W-1:0] c1_byte_len;
    logic [`HC_DATA_W-1:0] c1_data;
    logic c1_almost_full;
    logic c1_rsp_valid;
    logic [`HC_CL_LEN_W-1:0] c1_rsp_cl_num;
    logic [`HC_MDATA_W-1:0] c1_rsp_mdata;
    logic c1_rsp_fence;

    // Reference copy of host memory that follows every write beat issued
    logic [`HC_DATA_W-1:0] model [2**`HC_ADDR_W];
    logic [31:0] lfsr_state;
    // Set once the read channel has pushed back at least once
    bit saw_c0_full;

    // Responses expected on each channel in issue order
    logic [`HC_DATA_W-1:0] exp_rd_data [$];
    logic [`HC_CL_LEN_W-1:0] exp_rd_cl [$];
    logic [`HC_MDATA_W-1:0] exp_rd_mdata [$];
    logic [`HC_CL_LEN_W-1:0] exp_wr_cl [$];
    logic [`HC_MDATA_W-1:0] exp_wr_mdata [$];
    logic exp_wr_fence [$];
    // Responses collected from the DUT outputs
    logic [`HC_DATA_W-1:0] got_rd_data [$];
    logic [`HC_CL_LEN_W-1:0] got_rd_cl [$];
    logic [`HC_MDATA_W-1:0] got_rd_mdata [$];
    logic [`HC_CL_LEN_W-1:0] got_wr_cl [$];
    logic [`HC_MDATA_W-1:0] got_wr_mdata [$];
    logic got_wr_fence [$];

    tb_clock_gen clock_gen (.clk, .reset_n);

    host_chan_top uut (.*);

    // Responses are sampled on the falling edge half a cycle away from any change
    always @(negedge clk)
    begin
        if (reset_n && c0_rsp_valid)
        begin
            got_rd_data.push_back(c0_rsp_data);
            got_rd_cl.push_back(c0_rsp_cl_num);
            got_rd_mdata.push_back(c0_rsp_mdata);
        end
        if (reset_n && c1_rsp_valid)
        begin
            got_wr_cl.push_back(c1_rsp_cl_num);
            got_wr_mdata.push_back(c1_rsp_mdata);
            got_wr_fence.push_back(c1_rsp_fence);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
            abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    // Galois LFSR that shifts right and takes one step for every bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[62:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'hD000_0001;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return value;
    endfunction

    // Partial mode enables bytes from byte_start for byte_len bytes and full mode enables all
    function automatic logic [`HC_LINE_BYTES-1:0] byte_mask_for(input logic mode,
        input logic [`HC_BYTE_IDX_W-1:0] start, input logic [`HC_BYTE_LEN_W-1:0] len);
        logic [`HC_LINE_BYTES-1:0] mask;
        for (int b = 0; b < `HC_LINE_BYTES; b++)
            mask[b] = !mode || ((b >= int'(start)) && (b < int'(start) + int'(len)));
        return mask;
    endfunction

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (!reset_n)
        begin
            waited++;
            if (waited > 20)
                abort_run("Reset never released");
            else
                @(posedge clk);
        end
    endtask

    // Drives one beat on c1 and holds it back while the write FIFO reports almost full
    task automatic drive_c1(input logic [7:0] addr, input logic [1:0] len,
        input logic [7:0] mdata, input logic sop, input logic fence, input logic mode,
        input logic [2:0] bstart, input logic [3:0] blen, input logic [63:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        while (c1_almost_full)
        begin
            c1_valid <= 1'b0;
            waited++;
            if (waited > STALL_LIMIT)
                abort_run("The c1 channel stayed almost full for too long");
            else
                @(posedge clk);
        end
        c1_valid <= 1'b1;
        c1_sop <= sop;
        c1_fence <= fence;
        c1_address <= addr;
        c1_cl_len <= len;
        c1_mdata <= mdata;
        c1_mode <= mode;
        c1_byte_start <= bstart;
        c1_byte_len <= blen;
        c1_data <= data;
    endtask

    task automatic drive_c0(input logic [7:0] addr, input logic [1:0] len,
                            input logic [7:0] mdata);
        int waited;
        waited = 0;
        @(posedge clk);
        while (c0_almost_full)
        begin
            c0_valid <= 1'b0;
            saw_c0_full = 1'b1;
            waited++;
            if (waited > STALL_LIMIT)
                abort_run("The c0 channel stayed almost full for too long");
            else
                @(posedge clk);
        end
        c0_valid <= 1'b1;
        c0_address <= addr;
        c0_cl_len <= len;
        c0_mdata <= mdata;
    endtask

    task automatic end_c0();
        @(posedge clk);
        c0_valid <= 1'b0;
    endtask

    task automatic end_c1();
        @(posedge clk);
        c1_valid <= 1'b0;
    endtask

    // Drives a burst of random lines and merges them into the model with the expected byte mask
    task automatic issue_write(input logic [7:0] addr, input logic [1:0] len,
        input logic [7:0] mdata, input logic mode, input logic [2:0] bstart,
        input logic [3:0] blen);
        logic [`HC_LINE_BYTES-1:0] mask;
        logic [63:0] bits;
        logic [63:0] data;
        logic [7:0] line;
        mask = byte_mask_for(mode, bstart, blen);
        for (int b = 0; b < `HC_LINE_BYTES; b++)
            bits[8*b +: 8] = {8{mask[b]}};
        for (int i = 0; i <= int'(len); i++)
        begin
            data = rand_bits(64);
            line = addr + 8'(i);
            drive_c1(line, len, mdata, i == 0, 1'b0, mode, bstart, blen, data);
            model[line] = (model[line] & ~bits) | (data & bits);
        end
        exp_wr_cl.push_back(len);
        exp_wr_mdata.push_back(mdata);
        exp_wr_fence.push_back(1'b0);
    endtask

    task automatic issue_fence(input logic [7:0] mdata);
        drive_c1(8'h00, 2'd0, mdata, 1'b0, 1'b1, 1'b0, 3'd0, 4'd0, 64'h0);
        exp_wr_cl.push_back(2'd0);
        exp_wr_mdata.push_back(mdata);
        exp_wr_fence.push_back(1'b1);
    endtask

    // Each line of the burst is expected with its number and the model's data
    task automatic issue_read(input logic [7:0] addr, input logic [1:0] len,
                              input logic [7:0] mdata);
        drive_c0(addr, len, mdata);
        for (int i = 0; i <= int'(len); i++)
        begin
            exp_rd_data.push_back(model[addr + 8'(i)]);
            exp_rd_cl.push_back(2'(i));
            exp_rd_mdata.push_back(mdata);
        end
    endtask

    // Waits for every outstanding response and then matches them in order
    task automatic wait_responses();
        int waited;
        waited = 0;
        while ((got_rd_data.size() < exp_rd_data.size()) ||
               (got_wr_cl.size() < exp_wr_cl.size()))
        begin
            waited++;
            if (waited > RSP_LIMIT)
                abort_run("Timed out waiting for responses from the DUT");
            else
                @(posedge clk);
        end
        if ((got_rd_data.size() != exp_rd_data.size()) ||
            (got_wr_cl.size() != exp_wr_cl.size()))
            abort_run("The DUT returned more responses than were requested");
        else
        begin
            while (exp_rd_data.size() != 0)
            begin
                check_value("c0_rsp_data", got_rd_data.pop_front(), exp_rd_data.pop_front());
                check_value("c0_rsp_cl_num", got_rd_cl.pop_front(), exp_rd_cl.pop_front());
                check_value("c0_rsp_mdata", got_rd_mdata.pop_front(), exp_rd_mdata.pop_front());
            end
            while (exp_wr_cl.size() != 0)
            begin
                check_value("c1_rsp_cl_num", got_wr_cl.pop_front(), exp_wr_cl.pop_front());
                check_value("c1_rsp_mdata", got_wr_mdata.pop_front(), exp_wr_mdata.pop_front());
                check_value("c1_rsp_fence", got_wr_fence.pop_front(), exp_wr_fence.pop_front());
            end
        end
    endtask

    task automatic test_single_line();
        issue_write(8'h10, 2'd0, 8'h11, 1'b0, 3'd0, 4'd0);
        end_c1();
        wait_responses();
        issue_read(8'h10, 2'd0, 8'h12);
        end_c0();
        wait_responses();
    endtask

    task automatic test_burst();
        issue_write(8'h20, 2'd3, 8'h21, 1'b0, 3'd0, 4'd0);
        end_c1();
        wait_responses();
        issue_read(8'h20, 2'd3, 8'h22);
        end_c0();
        wait_responses();
    endtask

    // Each line gets a full write first so the partial write has old bytes to merge with
    task automatic test_partial();
        logic [2:0] bstart;
        logic [3:0] blen;
        for (int i = 0; i < 4; i++)
        begin
            issue_write(8'h30 + 8'(i), 2'd0, 8'h30 + 8'(i), 1'b0, 3'd0, 4'd0);
            bstart = 3'(rand_bits(3));
            blen = 4'(1 + (rand_bits(3) % (8 - int'(bstart))));
            issue_write(8'h30 + 8'(i), 2'd0, 8'h38 + 8'(i), 1'b1, bstart, blen);
            end_c1();
            wait_responses();
            issue_read(8'h30 + 8'(i), 2'd0, 8'h3C + 8'(i));
            end_c0();
            wait_responses();
        end
    endtask

    task automatic test_fence();
        issue_write(8'h40, 2'(rand_bits(2)), 8'h41, 1'b0, 3'd0, 4'd0);
        issue_write(8'h48, 2'(rand_bits(2)), 8'h42, 1'b0, 3'd0, 4'd0);
        issue_write(8'h50, 2'(rand_bits(2)), 8'h43, 1'b0, 3'd0, 4'd0);
        issue_fence(8'hF4);
        end_c1();
        wait_responses();
    endtask

    // Reads hit lines written earlier while writes fill a separate region
    task automatic test_concurrent();
        logic [1:0] rd_len [8];
        logic [1:0] wr_len [8];
        for (int k = 0; k < 8; k++)
        begin
            rd_len[k] = 2'(rand_bits(2));
            wr_len[k] = 2'(rand_bits(2));
        end
        fork
            begin
                for (int k = 0; k < 8; k++)
                    issue_read((k % 2) ? 8'h30 : 8'h20, rd_len[k], 8'hA0 + 8'(k));
                end_c0();
            end
            begin
                for (int k = 0; k < 8; k++)
                    issue_write(8'h80 + 8'(8 * k), wr_len[k], 8'h50 + 8'(k), 1'b0, 3'd0, 4'd0);
                end_c1();
            end
        join
        wait_responses();
        if (!saw_c0_full)
            abort_run("The c0 almost_full never asserted during back-pressure");
    endtask

    initial
    begin
        lfsr_state = 32'h8b5c_52b1;
        saw_c0_full = 1'b0;
        for (int a = 0; a < 2**`HC_ADDR_W; a++)
            model[a] = '0;
        c0_valid <= 1'b0;
        c0_address <= '0;
        c0_cl_len <= '0;
        c0_mdata <= '0;
        c1_valid <= 1'b0;
        c1_sop <= 1'b0;
        c1_fence <= 1'b0;
        c1_address <= '0;
        c1_cl_len <= '0;
        c1_mdata <= '0;
        c1_mode <= 1'b0;
        c1_byte_start <= '0;
        c1_byte_len <= '0;
        c1_data <= '0;
        wait_for_reset();
        @(negedge clk);
        check_value("c0_rsp_valid", c0_rsp_valid, 1'b0);
        check_value("c1_rsp_valid", c1_rsp_valid, 1'b0);
        check_value("c0_almost_full", c0_almost_full, 1'b0);
        check_value("c1_almost_full", c1_almost_full, 1'b0);
        test_single_line();
        test_burst();
        test_partial();
        test_fence();
        test_concurrent();
        $display("Test completed successfully");
        $finish;
    end

endmodule
